// File: dbg_path.sv
//--------------------------------------------------------------------------
// Debug request path
// Selects JTAG or DMI onto the debug module and routes the response back.
// Holds off the core debug request for a fixed time after reset
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sim_ctrl_params.svh"

module dbg_path #(
  parameter int holdoff_cycles_p = `SIM_HOLDOFF_CYCLES
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic                    jtag_sel_i,
  input  logic                    debug_req_raw_i,
  output logic                    debug_req_o,

  input  sim_ctrl_pkg::dmi_req_s  jtag_req_i,
  input  logic                    jtag_req_v_i,
  input  logic                    jtag_resp_ready_i,
  output logic                    jtag_resp_v_o,

  input  sim_ctrl_pkg::dmi_req_s  dmi_req_i,
  input  logic                    dmi_req_v_i,
  input  logic                    dmi_resp_ready_i,
  output logic                    dmi_resp_v_o,

  output logic                    req_ready_o,
  output sim_ctrl_pkg::dmi_resp_s resp_o,

  output sim_ctrl_pkg::dmi_req_s  dm_req_o,
  output logic                    dm_req_v_o,
  output logic                    dm_resp_ready_o,
  input  logic                    dm_req_ready_i,
  input  sim_ctrl_pkg::dmi_resp_s dm_resp_i,
  input  logic                    dm_resp_v_i
);

  localparam int cnt_w_lp = $clog2(holdoff_cycles_p + 1);

  logic [cnt_w_lp-1:0] holdoff_cnt_r;
  logic                holdoff_done;

  // Transport select
  assign dm_req_o        = jtag_sel_i ? jtag_req_i        : dmi_req_i;
  assign dm_req_v_o      = jtag_sel_i ? jtag_req_v_i      : dmi_req_v_i;
  assign dm_resp_ready_o = jtag_sel_i ? jtag_resp_ready_i : dmi_resp_ready_i;

  // Ready and response payload are shared, valid only goes to one side
  assign req_ready_o   = dm_req_ready_i;
  assign resp_o        = dm_resp_i;
  assign jtag_resp_v_o = jtag_sel_i & dm_resp_v_i;
  assign dmi_resp_v_o  = ~jtag_sel_i & dm_resp_v_i;

  // Gives the core time to run boot code before a debug halt
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      holdoff_cnt_r <= cnt_w_lp'(holdoff_cycles_p);
    end else if (!holdoff_done) begin
      holdoff_cnt_r <= holdoff_cnt_r - cnt_w_lp'(1);
    end
  end

  assign holdoff_done = (holdoff_cnt_r == '0);
  assign debug_req_o  = holdoff_done & debug_req_raw_i;

  // A response must never reach both transports
  a_one_resp_dest: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !(jtag_resp_v_o && dmi_resp_v_o)
  ) else $error("debug response routed to both JTAG and DMI");

endmodule

// File: host_regs.sv
//--------------------------------------------------------------------------
// Host register block
// Serves core I/O reads and writes to the trace enable and finish
// registers, one command in flight, one response per command
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sim_ctrl_params.svh"

module host_regs (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  sim_ctrl_pkg::host_cmd_s  cmd_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,

  output sim_ctrl_pkg::host_resp_s resp_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i,

  output sim_ctrl_pkg::trace_en_s  trace_en_o,
  output logic [`SIM_NUM_CORE-1:0] finish_o,
  output logic                     all_finish_o
);

  localparam int core_idx_w_lp = $clog2(`SIM_NUM_CORE);
  localparam int trace_w_lp    = $bits(sim_ctrl_pkg::trace_en_s);

  typedef enum logic [1:0] {
    REG_NONE,
    REG_TRACE,
    REG_FINISH
  } reg_sel_e;

  reg_sel_e                 reg_sel;
  logic                     accept;
  logic                     wr_accept;
  logic                     is_read;
  logic [core_idx_w_lp-1:0] finish_idx;
  sim_ctrl_pkg::host_resp_s resp_n;

  sim_ctrl_pkg::trace_en_s  trace_en_r;
  logic [`SIM_NUM_CORE-1:0] finish_r;
  sim_ctrl_pkg::host_resp_s resp_r;
  logic                     resp_v_r;

  // Address decode
  always_comb begin
    case (cmd_i.addr)
      `SIM_HOST_TRACE_ADDR:  reg_sel = REG_TRACE;
      `SIM_HOST_FINISH_ADDR: reg_sel = REG_FINISH;
      default:               reg_sel = REG_NONE;
    endcase
  end

  // Free when nothing is pending or the pending response leaves now
  assign cmd_ready_o = ~resp_v_r | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_read     = (cmd_i.op == sim_ctrl_pkg::HOST_RD);
  assign wr_accept   = accept & ~is_read;
  assign finish_idx  = cmd_i.data[core_idx_w_lp-1:0];

  // Response for the command now at the port
  always_comb begin
    resp_n.op   = cmd_i.op;
    resp_n.err  = 1'b0;
    resp_n.data = '0;
    case (reg_sel)
      REG_TRACE: begin
        if (is_read) begin
          resp_n.data = {{(`SIM_DATA_W - trace_w_lp){1'b0}}, trace_en_r};
        end
      end
      REG_FINISH: begin
        if (is_read) begin
          resp_n.data = {{(`SIM_DATA_W - `SIM_NUM_CORE){1'b0}}, finish_r};
        end
      end
      default: begin
        resp_n.err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      trace_en_r <= '0;
      finish_r   <= '0;
      resp_v_r   <= 1'b0;
    end else begin
      if (wr_accept && reg_sel == REG_TRACE) begin
        trace_en_r <= sim_ctrl_pkg::trace_en_s'(cmd_i.data[trace_w_lp-1:0]);
      end
      // Sticky until reset
      if (wr_accept && reg_sel == REG_FINISH) begin
        finish_r[finish_idx] <= 1'b1;
      end
      if (accept) begin
        resp_v_r <= 1'b1;
      end else if (resp_ready_i) begin
        resp_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_r <= resp_n;
    end
  end

  assign resp_o       = resp_r;
  assign resp_v_o     = resp_v_r;
  assign trace_en_o   = trace_en_r;
  assign finish_o     = finish_r;
  assign all_finish_o = &finish_r;

  // Response held steady under back-pressure
  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
      resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o)
  ) else $error("host response changed while stalled");

  // One command in flight
  a_no_overrun: assert property (
    @(posedge clk_i) disable iff (reset_i)
      resp_v_o && !resp_ready_i |-> !(cmd_v_i && cmd_ready_o)
  ) else $error("host command accepted over a pending response");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the simulation control testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_top \
  -f tb.f -o tb_sim > build.log 2>&1 &&
  { ./obj_dir/tb_sim > sim.log 2>&1 || true; } &&
  ! grep -q "TEST FAIL" sim.log &&
  grep -q "TEST PASS" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: sim_ctrl_params.svh
//--------------------------------------------------------------------------
// Simulation control constants
// Host channel widths, core count, host register map and debug holdoff
//--------------------------------------------------------------------------
`ifndef SIM_CTRL_PARAMS_SVH
`define SIM_CTRL_PARAMS_SVH

// Core count and host channel widths
`define SIM_NUM_CORE 4
`define SIM_ADDR_W 20
`define SIM_DATA_W 64

// Host register map
`define SIM_HOST_TRACE_ADDR 20'h00010
`define SIM_HOST_FINISH_ADDR 20'h00020

// Cycles the core debug request is blocked after reset
`define SIM_HOLDOFF_CYCLES 64

`endif

// File: sim_ctrl_pkg.sv
//--------------------------------------------------------------------------
// Simulation control types
// Opcodes, trace enable layout, host and debug transport messages
//--------------------------------------------------------------------------
`include "sim_ctrl_params.svh"

package sim_ctrl_pkg;

  typedef enum logic {
    HOST_RD = 1'b0,
    HOST_WR = 1'b1
  } host_op_e;

  // Bit positions in the trace enable register
  typedef enum logic [3:0] {
    ICACHE    = 4'd0,
    DCACHE    = 4'd1,
    LCE       = 4'd2,
    CCE       = 4'd3,
    DRAM      = 4'd4,
    VM        = 4'd5,
    CMT       = 4'd6,
    CORE_PROF = 4'd7,
    PC_PROF   = 4'd8,
    BR_PROF   = 4'd9,
    COSIM     = 4'd10
  } trace_sel_e;

  // MSB first, so icache lands on bit 0
  typedef struct packed {
    logic cosim;
    logic br_prof;
    logic pc_prof;
    logic core_prof;
    logic cmt;
    logic vm;
    logic dram;
    logic cce;
    logic lce;
    logic dcache;
    logic icache;
  } trace_en_s;

  typedef struct packed {
    host_op_e               op;
    logic [`SIM_ADDR_W-1:0] addr;
    logic [`SIM_DATA_W-1:0] data;
  } host_cmd_s;

  typedef struct packed {
    host_op_e               op;
    logic                   err;
    logic [`SIM_DATA_W-1:0] data;
  } host_resp_s;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dtm_op_e;

  typedef struct packed {
    logic [6:0]  addr;
    dtm_op_e     op;
    logic [31:0] data;
  } dmi_req_s;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_s;

endpackage

// File: sim_ctrl_top.sv
//--------------------------------------------------------------------------
// Simulation control top level
// Host register block beside the debug request path
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sim_ctrl_params.svh"

module sim_ctrl_top (
  input  logic                     clk_i,
  input  logic                     reset_i,

  // Host I/O channel
  input  sim_ctrl_pkg::host_cmd_s  cmd_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  output sim_ctrl_pkg::host_resp_s resp_o,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i,
  output sim_ctrl_pkg::trace_en_s  trace_en_o,
  output logic [`SIM_NUM_CORE-1:0] finish_o,
  output logic                     all_finish_o,

  // Debug transports
  input  logic                     jtag_sel_i,
  input  logic                     debug_req_raw_i,
  output logic                     debug_req_o,
  input  sim_ctrl_pkg::dmi_req_s   jtag_req_i,
  input  logic                     jtag_req_v_i,
  input  logic                     jtag_resp_ready_i,
  output logic                     jtag_resp_v_o,
  input  sim_ctrl_pkg::dmi_req_s   dmi_req_i,
  input  logic                     dmi_req_v_i,
  input  logic                     dmi_resp_ready_i,
  output logic                     dmi_resp_v_o,
  output logic                     req_ready_o,
  output sim_ctrl_pkg::dmi_resp_s  dbg_resp_o,

  // Debug module side
  output sim_ctrl_pkg::dmi_req_s   dm_req_o,
  output logic                     dm_req_v_o,
  output logic                     dm_resp_ready_o,
  input  logic                     dm_req_ready_i,
  input  sim_ctrl_pkg::dmi_resp_s  dm_resp_i,
  input  logic                     dm_resp_v_i
);

  host_regs host0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (cmd_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_ready_o  (cmd_ready_o),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_ready_i (resp_ready_i),
    .trace_en_o   (trace_en_o),
    .finish_o     (finish_o),
    .all_finish_o (all_finish_o)
  );

  // Debug response payload is renamed here, resp_o belongs to the host
  dbg_path #(
    .holdoff_cycles_p (`SIM_HOLDOFF_CYCLES)
  ) dbg0 (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .jtag_sel_i        (jtag_sel_i),
    .debug_req_raw_i   (debug_req_raw_i),
    .debug_req_o       (debug_req_o),
    .jtag_req_i        (jtag_req_i),
    .jtag_req_v_i      (jtag_req_v_i),
    .jtag_resp_ready_i (jtag_resp_ready_i),
    .jtag_resp_v_o     (jtag_resp_v_o),
    .dmi_req_i         (dmi_req_i),
    .dmi_req_v_i       (dmi_req_v_i),
    .dmi_resp_ready_i  (dmi_resp_ready_i),
    .dmi_resp_v_o      (dmi_resp_v_o),
    .req_ready_o       (req_ready_o),
    .resp_o            (dbg_resp_o),
    .dm_req_o          (dm_req_o),
    .dm_req_v_o        (dm_req_v_o),
    .dm_resp_ready_o   (dm_resp_ready_o),
    .dm_req_ready_i    (dm_req_ready_i),
    .dm_resp_i         (dm_resp_i),
    .dm_resp_v_i       (dm_resp_v_i)
  );

endmodule

// File: tb.f
+incdir+.
sim_ctrl_pkg.sv
host_regs.sv
dbg_path.sv
sim_ctrl_top.sv
tb_checker.sv
tb_top.sv

// File: tb_checker.sv
//--------------------------------------------------------------------------
// Simulation control checker
// Watches the DUT ports, runs a model of the host registers and the
// debug path, and counts mismatches
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sim_ctrl_params.svh"

module tb_checker (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  sim_ctrl_pkg::host_cmd_s  cmd_i,
  input  logic                     cmd_v_i,
  input  logic                     cmd_ready_i,
  input  sim_ctrl_pkg::host_resp_s resp_i,
  input  logic                     resp_v_i,
  input  logic                     resp_ready_i,
  input  sim_ctrl_pkg::trace_en_s  trace_en_i,
  input  logic [`SIM_NUM_CORE-1:0] finish_i,
  input  logic                     all_finish_i,
  input  logic                     jtag_sel_i,
  input  logic                     debug_req_raw_i,
  input  logic                     debug_req_i,
  input  sim_ctrl_pkg::dmi_req_s   jtag_req_i,
  input  logic                     jtag_req_v_i,
  input  logic                     jtag_resp_ready_i,
  input  logic                     jtag_resp_v_i,
  input  sim_ctrl_pkg::dmi_req_s   dmi_req_i,
  input  logic                     dmi_req_v_i,
  input  logic                     dmi_resp_ready_i,
  input  logic                     dmi_resp_v_i,
  input  logic                     req_ready_i,
  input  sim_ctrl_pkg::dmi_resp_s  dbg_resp_i,
  input  sim_ctrl_pkg::dmi_req_s   dm_req_i,
  input  logic                     dm_req_v_i,
  input  logic                     dm_resp_ready_i,
  input  logic                     dm_req_ready_i,
  input  sim_ctrl_pkg::dmi_resp_s  dm_resp_i,
  input  logic                     dm_resp_v_i,
  output int                       dbg_errs_o,
  output int                       host_errs_o
);

  sim_ctrl_pkg::trace_en_s  m_trace;
  logic [`SIM_NUM_CORE-1:0] m_finish;
  logic                     m_pend_v;
  sim_ctrl_pkg::host_resp_s m_pend;
  sim_ctrl_pkg::host_resp_s m_next;
  logic                     exp_ready;
  int                       post_cnt;
  int                       dbg_err_cnt = 0;
  int                       host_err_cnt = 0;

  assign dbg_errs_o  = dbg_err_cnt;
  assign host_errs_o = host_err_cnt;

  task automatic report_dbg(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    dbg_err_cnt++;
  endtask

  task automatic report_host(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    host_err_cnt++;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      m_trace  = '0;
      m_finish = '0;
      m_pend_v = 1'b0;
      post_cnt = 0;
    end else begin
      // Debug request held off, then passed through
      if (debug_req_i !== ((post_cnt >= `SIM_HOLDOFF_CYCLES) ? debug_req_raw_i : 1'b0)) begin
        report_dbg($sformatf("debug_req_o is %b, %0d cycles after reset", debug_req_i, post_cnt));
      end
      if (dm_req_i !== (jtag_sel_i ? jtag_req_i : dmi_req_i) ||
          dm_req_v_i !== (jtag_sel_i ? jtag_req_v_i : dmi_req_v_i) ||
          dm_resp_ready_i !== (jtag_sel_i ? jtag_resp_ready_i : dmi_resp_ready_i)) begin
        report_dbg($sformatf("dm request side does not follow jtag_sel_i=%b", jtag_sel_i));
      end
      if (jtag_resp_v_i !== (jtag_sel_i & dm_resp_v_i) ||
          dmi_resp_v_i !== (~jtag_sel_i & dm_resp_v_i)) begin
        report_dbg($sformatf("resp valid routed wrong, jtag %b dmi %b", jtag_resp_v_i,
                             dmi_resp_v_i));
      end
      if (req_ready_i !== dm_req_ready_i || dbg_resp_i !== dm_resp_i) begin
        report_dbg("shared ready or response payload differs from dm side");
      end

      // Host channel against the model
      exp_ready = ~m_pend_v | resp_ready_i;
      if (cmd_ready_i !== exp_ready) begin
        report_host($sformatf("cmd_ready_o is %b, expected %b", cmd_ready_i, exp_ready));
      end
      if (resp_v_i !== m_pend_v) begin
        report_host($sformatf("resp_v_o is %b, expected %b", resp_v_i, m_pend_v));
      end else if (m_pend_v && resp_i !== m_pend) begin
        report_host($sformatf("resp_o is %h, expected %h", resp_i, m_pend));
      end
      if (trace_en_i !== m_trace) begin
        report_host($sformatf("trace_en_o is %h, expected %h", trace_en_i, m_trace));
      end
      if (finish_i !== m_finish || all_finish_i !== (&m_finish)) begin
        report_host($sformatf("finish_o is %b all %b, expected %b", finish_i, all_finish_i,
                              m_finish));
      end

      if (cmd_v_i && exp_ready) begin
        m_next.op   = cmd_i.op;
        m_next.err  = 1'b0;
        m_next.data = '0;
        if (cmd_i.addr == `SIM_HOST_TRACE_ADDR) begin
          if (cmd_i.op == sim_ctrl_pkg::HOST_WR) begin
            m_trace = sim_ctrl_pkg::trace_en_s'(cmd_i.data[10:0]);
          end else begin
            m_next.data = 64'(m_trace);
          end
        end else if (cmd_i.addr == `SIM_HOST_FINISH_ADDR) begin
          if (cmd_i.op == sim_ctrl_pkg::HOST_WR) begin
            m_finish[cmd_i.data[1:0]] = 1'b1;
          end else begin
            m_next.data = 64'(m_finish);
          end
        end else begin
          m_next.err = 1'b1;
        end
        m_pend_v = 1'b1;
        m_pend   = m_next;
      end else if (resp_ready_i) begin
        m_pend_v = 1'b0;
      end
      post_cnt++;
    end
  end

endmodule

// File: tb_top.sv
//--------------------------------------------------------------------------
// Simulation control testbench
// Random host and debug traffic into the DUT, checked by tb_checker
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "sim_ctrl_params.svh"

module tb_top;

  localparam int reset_cycles_lp   = 4;
  localparam int traffic_cycles_lp = 2000;
  // Twice the traffic length leaves ample room for the drain
  localparam int timeout_cycles_lp = 2 * traffic_cycles_lp + 1000;

  logic                     clk_i = 1'b0;
  logic                     reset_i = 1'b1;
  sim_ctrl_pkg::host_cmd_s  cmd_i = '0;
  logic                     cmd_v_i = 1'b0;
  logic                     cmd_ready_o;
  sim_ctrl_pkg::host_resp_s resp_o;
  logic                     resp_v_o;
  logic                     resp_ready_i = 1'b0;
  sim_ctrl_pkg::trace_en_s  trace_en_o;
  logic [`SIM_NUM_CORE-1:0] finish_o;
  logic                     all_finish_o;
  logic                     jtag_sel_i = 1'b0;
  logic                     debug_req_raw_i = 1'b0;
  logic                     debug_req_o;
  sim_ctrl_pkg::dmi_req_s   jtag_req_i = '0;
  logic                     jtag_req_v_i = 1'b0;
  logic                     jtag_resp_ready_i = 1'b0;
  logic                     jtag_resp_v_o;
  sim_ctrl_pkg::dmi_req_s   dmi_req_i = '0;
  logic                     dmi_req_v_i = 1'b0;
  logic                     dmi_resp_ready_i = 1'b0;
  logic                     dmi_resp_v_o;
  logic                     req_ready_o;
  sim_ctrl_pkg::dmi_resp_s  dbg_resp_o;
  sim_ctrl_pkg::dmi_req_s   dm_req_o;
  logic                     dm_req_v_o;
  logic                     dm_resp_ready_o;
  logic                     dm_req_ready_i = 1'b0;
  sim_ctrl_pkg::dmi_resp_s  dm_resp_i = '0;
  logic                     dm_resp_v_i = 1'b0;

  logic [31:0]              rng_state = 32'd57948;
  int                       cycle_cnt = 0;
  int                       dbg_errs;
  int                       host_errs;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] a;
    r = next_rand();
    a = next_rand();
    cmd_v_i  = r[0] | r[1];
    cmd_i.op = sim_ctrl_pkg::host_op_e'(r[2]);
    // Mostly real registers, some random addresses
    case (r[5:3])
      3'd0, 3'd1, 3'd2: cmd_i.addr = `SIM_HOST_TRACE_ADDR;
      3'd3, 3'd4:       cmd_i.addr = `SIM_HOST_FINISH_ADDR;
      default:          cmd_i.addr = a[19:0];
    endcase
    cmd_i.data        = {next_rand(), next_rand()};
    resp_ready_i      = r[6] | r[7];
    jtag_sel_i        = r[8];
    debug_req_raw_i   = r[9];
    jtag_req_v_i      = r[10];
    dmi_req_v_i       = r[11];
    jtag_resp_ready_i = r[12];
    dmi_resp_ready_i  = r[13];
    dm_req_ready_i    = r[14];
    dm_resp_v_i       = r[15];
    jtag_req_i        = {a[6:0], a[8:7], next_rand()};
    dmi_req_i         = {a[15:9], a[17:16], next_rand()};
    dm_resp_i         = {next_rand(), a[21:20]};
  endtask

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (traffic_cycles_lp) begin
      drive_random();
      @(negedge clk_i);
    end
    // Drain the last response
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    @(negedge clk_i);
    while (resp_v_o) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    $display("Checker done: %0d debug errors, %0d host errors", dbg_errs, host_errs);
    if (dbg_errs + host_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles_lp) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles_lp);
      $display("TEST FAIL");
      $finish;
    end
  end

  sim_ctrl_top dut0 (.*);

  tb_checker chk0 (
    .*,
    .cmd_ready_i     (cmd_ready_o),
    .resp_i          (resp_o),
    .resp_v_i        (resp_v_o),
    .trace_en_i      (trace_en_o),
    .finish_i        (finish_o),
    .all_finish_i    (all_finish_o),
    .debug_req_i     (debug_req_o),
    .jtag_resp_v_i   (jtag_resp_v_o),
    .dmi_resp_v_i    (dmi_resp_v_o),
    .req_ready_i     (req_ready_o),
    .dbg_resp_i      (dbg_resp_o),
    .dm_req_i        (dm_req_o),
    .dm_req_v_i      (dm_req_v_o),
    .dm_resp_ready_i (dm_resp_ready_o),
    .dbg_errs_o      (dbg_errs),
    .host_errs_o     (host_errs)
  );

endmodule
